//--- biu_ahb.f
biu_core_pkg.sv
biu_ahb_pkg.sv
biu_ahb_master.sv
ahb_decoder.sv
ahb_sram_slave.sv
biu_ahb_subsys.sv
biu_ahb_properties.sv
tb_biu_ahb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_biu_ahb
LOG       ?= sim.log
FLIST     ?= biu_ahb.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_biu_ahb.sv
`timescale 1ns/1ps

module tb_biu_ahb;

  localparam int RESET_CYCLES  = 8;
  localparam int PLANNED_BEATS = 203;  // beats put on the bus by the tests below
  localparam int MAX_CYCLES    = 40 * PLANNED_BEATS + RESET_CYCLES + 200;
  localparam int KIND_WR  = 0;
  localparam int KIND_RD  = 1;
  localparam int KIND_ERR = 2;

  logic                   HCLK;
  logic                   HRESETn;
  biu_core_pkg::biu_req_t req;
  biu_core_pkg::biu_rsp_t rsp;
  biu_ahb_pkg::ahb_m2s_t  mon;

  biu_ahb_subsys u_biu_ahb_subsys (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .biu_req_i (req),
    .biu_rsp_o (rsp),
    .ahb_mon_o (mon)
  );

  logic [15:0] lfsr;
  logic [31:0] shadow [1024];  // reference memory
  logic [31:0] wbuf [16];      // write data of next request
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  int          exp_kind [$];
  logic [31:0] exp_ap_addr [$];  // first address phase of each request
  logic [31:0] exp_ap_ctl [$];
  logic        took_q;  // responses seen at last rising edge
  logic        dack_q;
  logic        hold_stb;  // core keeps stb up while a burst runs
  int          cycles;
  int          pop_kind;
  logic [31:0] pop_addr;
  logic [31:0] pop_data;
  logic [31:0] ap_addr;
  logic [31:0] ap_ctl;

  initial begin
    HCLK = 1'b0;
    forever #5 HCLK = ~HCLK;
  end

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
  endfunction

  function automatic int beats_of(input biu_core_pkg::biu_type_e bt);
    case (bt)
      biu_core_pkg::WRAP4, biu_core_pkg::INCR4:   return 4;
      biu_core_pkg::WRAP8, biu_core_pkg::INCR8:   return 8;
      biu_core_pkg::WRAP16, biu_core_pkg::INCR16: return 16;
      default:                                    return 1;
    endcase
  endfunction

  // address of beat k, wrap block is beats * 4 bytes
  function automatic logic [31:0] ref_beat_addr(input logic [31:0] start,
                                                input biu_core_pkg::biu_type_e bt, input int k);
    logic [31:0] blk;
    logic [31:0] lin;
    lin = start + 32'(4 * k);
    blk = 32'(4 * beats_of(bt)) - 32'd1;
    if (bt == biu_core_pkg::WRAP4 || bt == biu_core_pkg::WRAP8 || bt == biu_core_pkg::WRAP16)
      return (start & ~blk) | (lin & blk);
    return lin;
  endfunction

  function automatic logic ref_is_err(input logic [31:0] a);
    return a[31:12] != 20'd0;  // only 0x000..0xfff mapped
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic shadow_write(input logic [31:0] a, input biu_core_pkg::biu_size_e sz,
                              input logic [31:0] d);
    logic [3:0] be;
    case (sz)
      biu_core_pkg::BYTE:  be = 4'b0001 << a[1:0];
      biu_core_pkg::HWORD: be = a[1] ? 4'b1100 : 4'b0011;
      default:             be = 4'b1111;
    endcase
    for (int i = 0; i < 4; i++)
      if (be[i]) shadow[a[11:2]][8*i +: 8] = d[8*i +: 8];
  endtask

  ////////////////////////////////////////////////////////////
  // checking
  ////////////////////////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      fail_run($sformatf("ERROR at %0t ns: %s is %08h, expected %08h", $time, what, got, exp));
  endtask

  // compare process, pre-edge values of the response
  always @(posedge HCLK) begin
    took_q <= rsp.stb_ack;
    dack_q <= rsp.d_ack;
    if (HRESETn && took_q) begin  // taken last edge, its first beat is on the bus now
      if (exp_ap_addr.size() == 0)
        fail_run("request accepted with none outstanding");
      ap_addr = exp_ap_addr.pop_front();
      ap_ctl  = exp_ap_ctl.pop_front();
      check_equal("haddr", mon.haddr, ap_addr);
      check_equal("address phase controls",
                  {19'd0, mon.hprot, mon.htrans, mon.hwrite, mon.hsize, mon.hburst}, ap_ctl);
    end
    if (HRESETn && (rsp.ack || rsp.err)) begin
      if (exp_kind.size() == 0)
        fail_run("response seen with no beat outstanding");
      pop_kind = exp_kind.pop_front();
      pop_addr = exp_addr.pop_front();
      pop_data = exp_data.pop_front();
      check_equal("err", 32'(rsp.err), 32'(pop_kind == KIND_ERR));
      if (rsp.ack) check_equal("adro", rsp.adro, pop_addr);
      if (rsp.ack && pop_kind == KIND_RD) check_equal("q", rsp.q, pop_data);
    end
  end

  always @(posedge HCLK) begin
    cycles <= cycles + 1;
    if (cycles > MAX_CYCLES) fail_run("timeout, run went past its cycle limit");
  end

  ////////////////////////////////////////////////////////////
  // stimulus, always at the falling edge
  ////////////////////////////////////////////////////////////

  task automatic drain();
    while (exp_kind.size() != 0) @(negedge HCLK);
  endtask

  task automatic issue(input logic [31:0] adr, input biu_core_pkg::biu_size_e sz,
                       input biu_core_pkg::biu_type_e bt, input logic we);
    int          n;
    logic [31:0] a;
    n = beats_of(bt);
    if (ref_is_err(adr)) begin  // whole burst outside sram, one err
      exp_kind.push_back(KIND_ERR);
      exp_addr.push_back(adr);
      exp_data.push_back('0);
    end else begin
      for (int k = 0; k < n; k++) begin
        a = ref_beat_addr(adr, bt, k);
        if (we) shadow_write(a, sz, wbuf[k]);
        exp_kind.push_back(we ? KIND_WR : KIND_RD);
        exp_addr.push_back(a);
        exp_data.push_back(shadow[a[11:2]]);
      end
    end
    exp_ap_addr.push_back(adr);
    // hprot data and privileged, NONSEQ, AHB size and burst codes
    exp_ap_ctl.push_back({19'd0, 4'b0011, biu_ahb_pkg::HTRANS_NONSEQ, we, 3'(sz), 3'(bt)});
    req.stb   = 1'b1;
    req.adr   = adr;
    req.size  = sz;
    req.btype = bt;
    req.prot  = biu_core_pkg::PROT_DATA | biu_core_pkg::PROT_PRIVILEGED;
    req.lock  = 1'b0;
    req.we    = we;
    req.d     = wbuf[0];
    do @(negedge HCLK); while (!took_q);
    req.stb = hold_stb;  // held stb must not be taken again mid-burst
    for (int k = 1; k < n && !ref_is_err(adr); k++) begin
      req.d = wbuf[k];
      do @(negedge HCLK); while (!dack_q);
    end
    req.stb = 1'b0;  // a following request raises it again at once
  endtask

  task automatic fill_wbuf();
    for (int k = 0; k < 16; k++) rand_bits(32, wbuf[k]);
  endtask

  task automatic burst_pair(input biu_core_pkg::biu_type_e bt, input logic mid);
    logic [31:0] v;
    logic [31:0] a;
    int          n;
    n = beats_of(bt);
    rand_bits(10, v);
    a = {20'd0, v[9:0] & ~10'(n - 1), 2'b00};
    if (mid) begin  // start inside the wrap block
      rand_bits(4, v);
      v = v & 32'(n - 1);
      if (v == 0) v = 32'd1;
      a = a | {v[29:0], 2'b00};
    end
    fill_wbuf();
    issue(a, biu_core_pkg::WORD, bt, 1'b1);
    issue(a, biu_core_pkg::WORD, bt, 1'b0);
  endtask

  logic [31:0] addrs [8];
  logic [31:0] rv;

  initial begin
    lfsr     = 16'd55775;
    cycles   = 0;
    hold_stb = 1'b0;
    req      = '0;
    HRESETn  = 1'b0;
    repeat (RESET_CYCLES) @(negedge HCLK);
    HRESETn = 1'b1;
    @(negedge HCLK);

    // single word writes then reads, fast and slow half
    for (int i = 0; i < 8; i++) begin
      rand_bits(10, rv);
      addrs[i] = {20'd0, i[0], rv[8:0], 2'b00};
      fill_wbuf();
      issue(addrs[i], biu_core_pkg::WORD, biu_core_pkg::SINGLE, 1'b1);
    end
    for (int i = 0; i < 8; i++) issue(addrs[i], biu_core_pkg::WORD, biu_core_pkg::SINGLE, 1'b0);

    // byte and halfword lanes
    for (int i = 0; i < 8; i++) begin
      rand_bits(12, rv);
      fill_wbuf();
      issue({20'd0, rv[11:2], 2'b00}, biu_core_pkg::WORD, biu_core_pkg::SINGLE, 1'b1);
      for (int j = 0; j < 3; j++) begin
        rand_bits(2, addrs[0]);
        fill_wbuf();
        if (j == 1)
          issue({20'd0, rv[11:2], addrs[0][1], 1'b0}, biu_core_pkg::HWORD,
                biu_core_pkg::SINGLE, 1'b1);
        else
          issue({20'd0, rv[11:2], addrs[0][1:0]}, biu_core_pkg::BYTE,
                biu_core_pkg::SINGLE, 1'b1);
      end
      issue({20'd0, rv[11:2], 2'b00}, biu_core_pkg::WORD, biu_core_pkg::SINGLE, 1'b0);
    end

    burst_pair(biu_core_pkg::INCR4, 1'b0);
    burst_pair(biu_core_pkg::INCR8, 1'b0);
    burst_pair(biu_core_pkg::INCR16, 1'b0);
    burst_pair(biu_core_pkg::WRAP4, 1'b1);
    burst_pair(biu_core_pkg::WRAP8, 1'b1);
    burst_pair(biu_core_pkg::WRAP16, 1'b1);

    // unmapped, then a normal access
    drain();
    issue(32'h0000_1000, biu_core_pkg::WORD, biu_core_pkg::SINGLE, 1'b0);
    drain();
    burst_pair(biu_core_pkg::SINGLE, 1'b0);
    drain();
    issue(32'h0001_0000, biu_core_pkg::WORD, biu_core_pkg::INCR4, 1'b1);
    drain();
    burst_pair(biu_core_pkg::SINGLE, 1'b0);
    drain();
    issue(32'h2000_0048, biu_core_pkg::WORD, biu_core_pkg::WRAP8, 1'b0);
    drain();
    burst_pair(biu_core_pkg::SINGLE, 1'b0);

    // back to back bursts, stb held through each burst and between them
    hold_stb = 1'b1;
    for (int i = 0; i < 3; i++) burst_pair(biu_core_pkg::INCR4, 1'b0);

    drain();
    repeat (4) @(negedge HCLK);  // room for a stray response
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- biu_ahb_properties.sv
`timescale 1ns/1ps

module biu_ahb_properties (
  input logic                   HCLK,
  input logic                   HRESETn,
  input biu_core_pkg::biu_rsp_t rsp_i,
  input biu_ahb_pkg::ahb_m2s_t  ahb_m2s_i,
  input biu_ahb_pkg::ahb_s2m_t  ahb_s2m_i
);

  logic active;  // NONSEQ or SEQ on the bus
  assign active = (ahb_m2s_i.htrans == biu_ahb_pkg::HTRANS_NONSEQ) |
                  (ahb_m2s_i.htrans == biu_ahb_pkg::HTRANS_SEQ);

  // wait state holds the address phase, ERROR may drop it
  a_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (active && !ahb_s2m_i.hready && ahb_s2m_i.hresp == biu_ahb_pkg::HRESP_OKAY) |=>
    ($stable(ahb_m2s_i.haddr) && $stable(ahb_m2s_i.htrans) && $stable(ahb_m2s_i.hwrite) &&
     $stable(ahb_m2s_i.hsize) && $stable(ahb_m2s_i.hburst)))
    else $error("address phase changed during wait state");

  a_seq: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (ahb_m2s_i.htrans == biu_ahb_pkg::HTRANS_SEQ) |->
    ($past(ahb_m2s_i.htrans) == biu_ahb_pkg::HTRANS_NONSEQ ||
     $past(ahb_m2s_i.htrans) == biu_ahb_pkg::HTRANS_SEQ))
    else $error("SEQ without preceding NONSEQ or SEQ");

  a_err_pulse: assert property (@(posedge HCLK) disable iff (!HRESETn)
    rsp_i.err |=> !rsp_i.err)
    else $error("err longer than one cycle");

  // a taken request opens a new burst, a beat still owed would show up as SEQ
  a_stb_ack: assert property (@(posedge HCLK) disable iff (!HRESETn)
    rsp_i.stb_ack |=> (ahb_m2s_i.htrans == biu_ahb_pkg::HTRANS_NONSEQ))
    else $error("stb_ack while burst beats remain");

endmodule

bind biu_ahb_master biu_ahb_properties u_props (
  .HCLK      (HCLK),
  .HRESETn   (HRESETn),
  .rsp_i     (biu_rsp_o),
  .ahb_m2s_i (ahb_o),
  .ahb_s2m_i (ahb_i)
);

//--- biu_ahb_subsys.sv
`timescale 1ns/1ps

module biu_ahb_subsys (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  biu_core_pkg::biu_req_t biu_req_i,
  output biu_core_pkg::biu_rsp_t biu_rsp_o,
  output biu_ahb_pkg::ahb_m2s_t  ahb_mon_o   // master side of the bus
);

  ////////////////////////////////////////////////////////////
  // bus wires
  ////////////////////////////////////////////////////////////

  biu_ahb_pkg::ahb_s2m_t ahb_s2m;   // selected response back to master
  biu_ahb_pkg::ahb_m2s_t sram_m2s;  // hsel gated by decoder
  biu_ahb_pkg::ahb_s2m_t sram_s2m;

  biu_ahb_master u_master (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .biu_req_i (biu_req_i),
    .biu_rsp_o (biu_rsp_o),
    .ahb_o     (ahb_mon_o),
    .ahb_i     (ahb_s2m)
  );

  // decoder holds the default slave
  ahb_decoder u_decoder (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .ahb_i   (ahb_mon_o),
    .sram_o  (sram_m2s),
    .sram_i  (sram_s2m),
    .ahb_o   (ahb_s2m)
  );

  ahb_sram_slave u_sram (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .ahb_i   (sram_m2s),
    .ahb_o   (sram_s2m)
  );

endmodule

//--- ahb_sram_slave.sv
`timescale 1ns/1ps

module ahb_sram_slave (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  biu_ahb_pkg::ahb_m2s_t ahb_i,
  output biu_ahb_pkg::ahb_s2m_t ahb_o
);

  // byte lanes for one transfer
  function automatic logic [3:0] lane_mask(
    input biu_ahb_pkg::hsize_e hsize,
    input logic [1:0]          lsb
  );
    case (hsize)
      biu_ahb_pkg::HSIZE_BYTE:  return 4'b0001 << lsb;
      biu_ahb_pkg::HSIZE_HWORD: return 4'b0011 << {lsb[1], 1'b0};
      default:                  return 4'b1111;
    endcase
  endfunction

  logic [biu_core_pkg::XLEN-1:0] mem [biu_ahb_pkg::SRAM_WORDS];

  // data phase state
  logic                                  dp_valid_q;  // transfer in data phase
  logic                                  dp_write_q;
  biu_ahb_pkg::hsize_e                   dp_size_q;
  logic [biu_ahb_pkg::SRAM_ADDR_BITS-1:0] dp_addr_q;   // byte address inside window
  logic [1:0]                            wait_cnt;    // wait states left

  logic       ready;
  logic       ap_take;  // address phase accepted this edge
  logic       wr_en;
  logic [3:0] be;
  logic [biu_ahb_pkg::SRAM_ADDR_BITS-3:0] word_idx;

  assign ready    = (wait_cnt == '0);
  assign ap_take  = ahb_i.hsel & ready &
                    ((ahb_i.htrans == biu_ahb_pkg::HTRANS_NONSEQ) |
                     (ahb_i.htrans == biu_ahb_pkg::HTRANS_SEQ));
  assign word_idx = dp_addr_q[biu_ahb_pkg::SRAM_ADDR_BITS-1:2];
  assign be       = lane_mask(dp_size_q, dp_addr_q[1:0]);
  assign wr_en    = ready & dp_valid_q & dp_write_q;  // hwdata valid on last data cycle

  ////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      dp_valid_q <= 1'b0;
      wait_cnt   <= '0;
    end else if (ready) begin
      dp_valid_q <= ap_take;
      if (ap_take && ahb_i.haddr[biu_ahb_pkg::SLOW_BIT]) begin
        wait_cnt <= 2'(biu_ahb_pkg::SLOW_WAITS);  // slow half
      end
    end else begin
      wait_cnt <= wait_cnt - 1'b1;  // count down to HREADY
    end
  end

  always_ff @(posedge HCLK) begin
    if (ap_take) begin
      dp_write_q <= ahb_i.hwrite;
      dp_size_q  <= ahb_i.hsize;
      dp_addr_q  <= ahb_i.haddr[biu_ahb_pkg::SRAM_ADDR_BITS-1:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK) begin
    if (wr_en) begin
      for (int i = 0; i < biu_core_pkg::XLEN / 8; i++) begin
        if (be[i]) begin
          mem[word_idx][8*i +: 8] <= ahb_i.hwdata[8*i +: 8];
        end
      end
    end
  end

  // whole word read, lane picking is up to the master
  assign ahb_o = '{
    hrdata: mem[word_idx],
    hready: ready,
    hresp:  biu_ahb_pkg::HRESP_OKAY  // never errors
  };

endmodule

//--- ahb_decoder.sv
`timescale 1ns/1ps

module ahb_decoder (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  biu_ahb_pkg::ahb_m2s_t ahb_i,   // from master
  output biu_ahb_pkg::ahb_m2s_t sram_o,
  input  biu_ahb_pkg::ahb_s2m_t sram_i,
  output biu_ahb_pkg::ahb_s2m_t ahb_o    // to master
);

  logic hit_sram;   // address phase falls in sram window
  logic active;     // NONSEQ or SEQ
  logic unmapped;   // default slave owns this transfer
  logic sram_dp_q;  // sram owns the data phase
  logic err1_q;     // ERROR, HREADY low
  logic err2_q;     // ERROR, HREADY high

  assign hit_sram = ahb_i.haddr[biu_core_pkg::PLEN-1:biu_ahb_pkg::SRAM_ADDR_BITS] ==
                    biu_ahb_pkg::SRAM_BASE[biu_core_pkg::PLEN-1:biu_ahb_pkg::SRAM_ADDR_BITS];
  assign active   = (ahb_i.htrans == biu_ahb_pkg::HTRANS_NONSEQ) |
                    (ahb_i.htrans == biu_ahb_pkg::HTRANS_SEQ);
  assign unmapped = ahb_i.hsel & active & ~hit_sram;

  ////////////////////////////////////////////////////////////
  // data phase owner and default slave
  ////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      sram_dp_q <= 1'b0;
      err1_q    <= 1'b0;
      err2_q    <= 1'b0;
    end else begin
      err2_q <= err1_q;  // second ERROR cycle always follows the first
      if (ahb_o.hready) begin
        sram_dp_q <= ahb_i.hsel & hit_sram;
        err1_q    <= unmapped;
      end else begin
        err1_q <= 1'b0;
      end
    end
  end

  // response mux
  always_comb begin
    if (sram_dp_q) begin
      ahb_o = sram_i;
    end else begin
      ahb_o.hrdata = '0;
      ahb_o.hready = ~err1_q;
      ahb_o.hresp  = (err1_q | err2_q) ? biu_ahb_pkg::HRESP_ERROR : biu_ahb_pkg::HRESP_OKAY;
    end
  end

  // sram only sees hsel on bus-ready cycles, so it samples with the global HREADY
  always_comb begin
    sram_o      = ahb_i;
    sram_o.hsel = ahb_i.hsel & hit_sram & ahb_o.hready;
  end

endmodule

//--- biu_ahb_master.sv
`timescale 1ns/1ps

module biu_ahb_master (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  biu_core_pkg::biu_req_t biu_req_i,
  output biu_core_pkg::biu_rsp_t biu_rsp_o,
  output biu_ahb_pkg::ahb_m2s_t  ahb_o,
  input  biu_ahb_pkg::ahb_s2m_t  ahb_i
);

  ////////////////////////////////////////////////////////////
  // request to bus conversion
  ////////////////////////////////////////////////////////////

  function automatic biu_ahb_pkg::hsize_e size2hsize(input biu_core_pkg::biu_size_e size);
    case (size)
      biu_core_pkg::BYTE:  return biu_ahb_pkg::HSIZE_BYTE;
      biu_core_pkg::HWORD: return biu_ahb_pkg::HSIZE_HWORD;
      default:             return biu_ahb_pkg::HSIZE_WORD;
    endcase
  endfunction

  // beats left after the first one
  function automatic logic [3:0] type2cnt(input biu_core_pkg::biu_type_e btype);
    case (btype)
      biu_core_pkg::WRAP4, biu_core_pkg::INCR4:   return 4'd3;
      biu_core_pkg::WRAP8, biu_core_pkg::INCR8:   return 4'd7;
      biu_core_pkg::WRAP16, biu_core_pkg::INCR16: return 4'd15;
      default:                                    return 4'd0;  // SINGLE, INCR
    endcase
  endfunction

  function automatic biu_ahb_pkg::hburst_e type2hburst(input biu_core_pkg::biu_type_e btype);
    case (btype)
      biu_core_pkg::INCR:   return biu_ahb_pkg::HBURST_INCR;
      biu_core_pkg::WRAP4:  return biu_ahb_pkg::HBURST_WRAP4;
      biu_core_pkg::INCR4:  return biu_ahb_pkg::HBURST_INCR4;
      biu_core_pkg::WRAP8:  return biu_ahb_pkg::HBURST_WRAP8;
      biu_core_pkg::INCR8:  return biu_ahb_pkg::HBURST_INCR8;
      biu_core_pkg::WRAP16: return biu_ahb_pkg::HBURST_WRAP16;
      biu_core_pkg::INCR16: return biu_ahb_pkg::HBURST_INCR16;
      default:              return biu_ahb_pkg::HBURST_SINGLE;
    endcase
  endfunction

  function automatic logic [3:0] prot2hprot(input logic [2:0] prot);
    logic [3:0] hprot;
    hprot = '0;  // opcode, user, non-cacheable
    if (|(prot & biu_core_pkg::PROT_DATA))
      hprot |= biu_ahb_pkg::HPROT_DATA;
    if (|(prot & biu_core_pkg::PROT_PRIVILEGED))
      hprot |= biu_ahb_pkg::HPROT_PRIVILEGED;
    if (|(prot & biu_core_pkg::PROT_CACHEABLE))
      hprot |= biu_ahb_pkg::HPROT_CACHEABLE;
    return hprot;
  endfunction

  // next beat address, word steps, wrapping bursts stay inside their block
  function automatic logic [biu_core_pkg::PLEN-1:0] nxt_addr(
    input logic [biu_core_pkg::PLEN-1:0] addr,
    input biu_ahb_pkg::hburst_e          hburst
  );
    logic [biu_core_pkg::PLEN-1:0] lin;
    lin = {addr[biu_core_pkg::PLEN-1:2] + 1'b1, 2'b00};
    case (hburst)
      biu_ahb_pkg::HBURST_WRAP4:  return {addr[biu_core_pkg::PLEN-1:4], lin[3:0]};  // 16 B
      biu_ahb_pkg::HBURST_WRAP8:  return {addr[biu_core_pkg::PLEN-1:5], lin[4:0]};  // 32 B
      biu_ahb_pkg::HBURST_WRAP16: return {addr[biu_core_pkg::PLEN-1:6], lin[5:0]};  // 64 B
      default:                    return lin;
    endcase
  endfunction

  // address phase registers
  logic                          hsel_q;
  logic [biu_core_pkg::PLEN-1:0] haddr_q;
  logic                          hwrite_q;
  biu_ahb_pkg::hsize_e           hsize_q;
  biu_ahb_pkg::hburst_e          hburst_q;
  logic [3:0]                    hprot_q;
  biu_ahb_pkg::htrans_e          htrans_q;
  logic                          hmastlock_q;

  logic [3:0] burst_cnt;   // beats still to issue
  logic       data_ena;    // address phase on the bus
  logic       data_ena_d;  // same, moved into data phase
  logic       err_q;

  logic [biu_core_pkg::XLEN-1:0] d_dly;     // first stage, lines up with address phase
  logic [biu_core_pkg::XLEN-1:0] hwdata_q;  // second stage, data phase
  logic [biu_core_pkg::PLEN-1:0] adro_q;    // address of beat in data phase

  logic hready;
  logic hresp_err;
  logic stb_ack;

  assign hready    = ahb_i.hready;
  assign hresp_err = (ahb_i.hresp == biu_ahb_pkg::HRESP_ERROR);
  // new request only between bursts, never in the error pulse cycle
  assign stb_ack   = hready & ~|burst_cnt & biu_req_i.stb & ~err_q;

  ////////////////////////////////////////////////////////////
  // address phase
  ////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      hsel_q      <= 1'b0;
      haddr_q     <= '0;
      hwrite_q    <= 1'b0;
      hsize_q     <= biu_ahb_pkg::HSIZE_WORD;
      hburst_q    <= biu_ahb_pkg::HBURST_SINGLE;
      hprot_q     <= biu_ahb_pkg::HPROT_DATA | biu_ahb_pkg::HPROT_PRIVILEGED;
      htrans_q    <= biu_ahb_pkg::HTRANS_IDLE;
      hmastlock_q <= 1'b0;
      burst_cnt   <= '0;
      data_ena    <= 1'b0;
      err_q       <= 1'b0;
    end else begin
      err_q <= 1'b0;  // pulse
      if (hready) begin
        if (|burst_cnt) begin  // next beat of running burst
          burst_cnt <= burst_cnt - 1'b1;
          data_ena  <= 1'b1;
          htrans_q  <= biu_ahb_pkg::HTRANS_SEQ;
          haddr_q   <= nxt_addr(haddr_q, hburst_q);
        end else if (stb_ack) begin  // start of a new transfer
          burst_cnt   <= type2cnt(biu_req_i.btype);
          data_ena    <= 1'b1;
          hsel_q      <= 1'b1;
          htrans_q    <= biu_ahb_pkg::HTRANS_NONSEQ;
          haddr_q     <= biu_req_i.adr;
          hwrite_q    <= biu_req_i.we;
          hsize_q     <= size2hsize(biu_req_i.size);
          hburst_q    <= type2hburst(biu_req_i.btype);
          hprot_q     <= prot2hprot(biu_req_i.prot);
          hmastlock_q <= biu_req_i.lock;
        end else begin
          data_ena    <= 1'b0;
          hsel_q      <= 1'b0;
          htrans_q    <= biu_ahb_pkg::HTRANS_IDLE;
          hmastlock_q <= biu_req_i.lock;  // lock may span idle gaps
        end
      end else if (hresp_err) begin
        // first ERROR cycle, drop what is left of the burst
        burst_cnt <= '0;
        data_ena  <= 1'b0;
        hsel_q    <= 1'b0;
        htrans_q  <= biu_ahb_pkg::HTRANS_IDLE;
        err_q     <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // data phase
  ////////////////////////////////////////////////////////////

  // write data comes with the address phase it belongs to, beat 0 with stb_ack
  always_ff @(posedge HCLK) begin
    if (hready) begin
      d_dly    <= biu_req_i.d;
      hwdata_q <= d_dly;
      adro_q   <= haddr_q;
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      data_ena_d <= 1'b0;
    end else if (hready) begin
      data_ena_d <= data_ena;
    end
  end

  assign ahb_o = '{
    hsel:      hsel_q,
    haddr:     haddr_q,
    hwrite:    hwrite_q,
    hsize:     hsize_q,
    hburst:    hburst_q,
    hprot:     hprot_q,
    htrans:    htrans_q,
    hmastlock: hmastlock_q,
    hwdata:    hwdata_q
  };

  // no ack on the closing ERROR cycle, err covers that beat
  assign biu_rsp_o = '{
    stb_ack: stb_ack,
    d_ack:   hready & data_ena,
    ack:     hready & data_ena_d & ~hresp_err,
    err:     err_q,
    q:       ahb_i.hrdata,
    adro:    adro_q
  };

endmodule

//--- biu_ahb_pkg.sv
package biu_ahb_pkg;

  ////////////////////////////////////////////////////////////
  // AHB-Lite encodings
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  typedef enum logic [2:0] {
    HBURST_SINGLE = 3'd0,
    HBURST_INCR   = 3'd1,
    HBURST_WRAP4  = 3'd2,
    HBURST_INCR4  = 3'd3,
    HBURST_WRAP8  = 3'd4,
    HBURST_INCR8  = 3'd5,
    HBURST_WRAP16 = 3'd6,
    HBURST_INCR16 = 3'd7
  } hburst_e;

  typedef enum logic [2:0] {
    HSIZE_BYTE  = 3'd0,
    HSIZE_HWORD = 3'd1,
    HSIZE_WORD  = 3'd2,
    HSIZE_DWORD = 3'd3,
    HSIZE_B128  = 3'd4,
    HSIZE_B256  = 3'd5,
    HSIZE_B512  = 3'd6,
    HSIZE_B1024 = 3'd7
  } hsize_e;

  typedef enum logic {
    HRESP_OKAY  = 1'b0,
    HRESP_ERROR = 1'b1
  } hresp_e;

  // HPROT bits, a clear bit means opcode / user / non-bufferable / non-cacheable
  localparam logic [3:0] HPROT_DATA       = 4'b0001;
  localparam logic [3:0] HPROT_PRIVILEGED = 4'b0010;
  localparam logic [3:0] HPROT_BUFFERABLE = 4'b0100;
  localparam logic [3:0] HPROT_CACHEABLE  = 4'b1000;

  ////////////////////////////////////////////////////////////
  // memory map
  ////////////////////////////////////////////////////////////

  localparam logic [biu_core_pkg::PLEN-1:0] SRAM_BASE = '0;
  localparam int SRAM_WORDS     = 1024;
  localparam int SRAM_ADDR_BITS = $clog2(SRAM_WORDS) + 2;  // byte address bits, 4 KiB window
  localparam int SLOW_BIT       = 11;  // upper half of sram is the slow half
  localparam int SLOW_WAITS     = 2;

  typedef struct packed {
    logic                          hsel;
    logic [biu_core_pkg::PLEN-1:0] haddr;
    logic                          hwrite;
    hsize_e                        hsize;
    hburst_e                       hburst;
    logic [3:0]                    hprot;
    htrans_e                       htrans;
    logic                          hmastlock;
    logic [biu_core_pkg::XLEN-1:0] hwdata;  // data phase
  } ahb_m2s_t;

  typedef struct packed {
    logic [biu_core_pkg::XLEN-1:0] hrdata;
    logic                          hready;
    hresp_e                        hresp;
  } ahb_s2m_t;

endpackage

//--- biu_core_pkg.sv
package biu_core_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  localparam int XLEN = 32;  // data path
  localparam int PLEN = 32;  // physical address

  ////////////////////////////////////////////////////////////
  // request encodings
  ////////////////////////////////////////////////////////////

  // burst type as issued by the core
  typedef enum logic [2:0] {
    SINGLE = 3'd0,
    INCR   = 3'd1,  // undefined length, one beat per request here
    WRAP4  = 3'd2,
    INCR4  = 3'd3,
    WRAP8  = 3'd4,
    INCR8  = 3'd5,
    WRAP16 = 3'd6,
    INCR16 = 3'd7
  } biu_type_e;

  typedef enum logic [2:0] {
    BYTE  = 3'd0,
    HWORD = 3'd1,
    WORD  = 3'd2   // widest legal size at 32 bits
  } biu_size_e;

  // protection field, one bit each
  localparam logic [2:0] PROT_DATA       = 3'b001;  // clear means opcode fetch
  localparam logic [2:0] PROT_PRIVILEGED = 3'b010;
  localparam logic [2:0] PROT_CACHEABLE  = 3'b100;

  typedef struct packed {
    logic            stb;    // held until stb_ack
    logic [PLEN-1:0] adr;
    biu_size_e       size;
    biu_type_e       btype;
    logic [2:0]      prot;   // PROT_* bits
    logic            lock;
    logic            we;
    logic [XLEN-1:0] d;      // write data, sampled with each address phase
  } biu_req_t;

  typedef struct packed {
    logic            stb_ack;  // request taken
    logic            d_ack;    // present next beat's data
    logic            ack;      // one per finished beat
    logic            err;      // one cycle, burst dropped
    logic [XLEN-1:0] q;
    logic [PLEN-1:0] adro;     // address of the acked beat
  } biu_rsp_t;

endpackage
